// File: Makefile
# mini816 simulation and lint with Verilator

TOP := mini816_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f mini816.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@grep -qx "Test OK" sim.log

lint:
	verilator --lint-only --timing -Wall -f mini816.f --top-module mini816_top

clean:
	rm -rf obj_dir sim.log

// File: hdl/addr_reg.sv
`timescale 1ns/1ps
// mini816 address register
// 24-bit operand and data register, written one byte at a time

module addr_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [2:0]          addr_write,
    input  logic [7:0]          alu_y,
    input  logic [7:0]          mem_rdata,
    input  logic                mv_byte,
    output cpu_pkg::long_addr_u addr
);

    logic [7:0] wbyte;

    assign wbyte = mv_byte ? mem_rdata : alu_y; // raw byte during block moves

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (addr_write[i]) begin
                    addr.bytes[i] <= wbyte;
                end
            end
        end
    end

endmodule

// File: hdl/alu_unit.sv
`timescale 1ns/1ps
// mini816 ALU
// selects two 16-bit operands and adds or subtracts them

module alu_unit (
    input  cpu_pkg::alu_a_sel_e alu_a_sel,
    input  cpu_pkg::alu_b_sel_e alu_b_sel,
    input  cpu_pkg::alu_ctl_e   alu_ctl,
    input  logic [15:0]         a,
    input  logic [15:0]         x,
    input  logic [15:0]         y,
    input  logic [15:0]         sp,
    input  logic [15:0]         pc,
    input  logic [15:0]         addr_off,
    input  logic [7:0]          mem_rdata,
    output logic [15:0]         alu_y
);

    logic [15:0] op_a, op_b;

    always_comb begin
        case (alu_a_sel)
            cpu_pkg::AA_A:  op_a = a;
            cpu_pkg::AA_X:  op_a = x;
            cpu_pkg::AA_Y:  op_a = y;
            cpu_pkg::AA_SP: op_a = sp;
            cpu_pkg::AA_PC: op_a = pc;
            default:        op_a = 16'h0000;
        endcase
        case (alu_b_sel)
            cpu_pkg::AB_RD: op_b = {8'h00, mem_rdata}; // zero extended
            cpu_pkg::AB_1:  op_b = 16'h0001;
            cpu_pkg::AB_2:  op_b = 16'h0002;
            default:        op_b = addr_off;
        endcase
    end

    assign alu_y = (alu_ctl == cpu_pkg::ACTL_SUB) ? op_a - op_b : op_a + op_b;

endmodule

// File: hdl/cpu_pkg.sv
// mini816 shared definitions
// sequencer states, opcodes, datapath selects and the long address type

package cpu_pkg;

    // ======================================================================
    // sequencer states
    // ======================================================================
    typedef enum logic [3:0] {
        S_FETCH_OPCODE,
        S_FETCH_OPRAND_L,
        S_FETCH_OPRAND_H,
        S_OP_CALC,
        S_PUSH_H,
        S_PUSH_L,
        S_PULL_L,
        S_PULL_H,
        S_FETCH_BANK,
        S_MV_READ,
        S_MV_WRITE,
        S_DEC_A,
        S_MV_LOOP,
        S_HALT
    } state_e;

    // ======================================================================
    // opcodes
    // ======================================================================
    localparam logic [7:0] OP_LDA_IMM = 8'hA9;
    localparam logic [7:0] OP_LDX_IMM = 8'hA2;
    localparam logic [7:0] OP_LDY_IMM = 8'hA0;
    localparam logic [7:0] OP_PHA     = 8'h48;
    localparam logic [7:0] OP_PHX     = 8'hDA;
    localparam logic [7:0] OP_PHY     = 8'h5A;
    localparam logic [7:0] OP_PLA     = 8'h68;
    localparam logic [7:0] OP_PLX     = 8'hFA;
    localparam logic [7:0] OP_PLY     = 8'h7A;
    localparam logic [7:0] OP_MVN     = 8'h54;
    localparam logic [7:0] OP_MVP     = 8'h44;
    localparam logic [7:0] OP_STP     = 8'hDB;

    // ======================================================================
    // datapath selects
    // ======================================================================
    typedef enum logic [2:0] {AA_A, AA_X, AA_Y, AA_SP, AA_PC, AA_0} alu_a_sel_e;
    typedef enum logic [1:0] {AB_RD, AB_1, AB_2, AB_ADDR} alu_b_sel_e;
    typedef enum logic {ACTL_ADD, ACTL_SUB} alu_ctl_e;
    typedef enum logic [2:0] {MA_PC, MA_SP, MA_SP_1, MA_X, MA_Y} mem_addr_sel_e;
    typedef enum logic [2:0] {
        MW_AL, MW_AH, MW_XL, MW_XH, MW_YL, MW_YH, MW_ADDRL
    } mem_wdata_sel_e;
    typedef enum logic [1:0] {RW_ALUY, RW_ADDR, RW_RD} reg_wdata_sel_e;
    typedef enum logic {PCW_PC_1, PCW_ALUY} pc_wdata_sel_e;

    localparam int L = 0; // byte indices
    localparam int H = 1;
    localparam int B = 2;

    // 24-bit address, seen as bytes or as bank plus offset
    typedef union packed {
        logic [2:0][7:0] bytes;
        struct packed {
            logic [7:0]  bank;
            logic [15:0] offset;
        } f;
    } long_addr_u;

endpackage

// File: hdl/cpu_sequencer.sv
`timescale 1ns/1ps
// mini816 sequencer
// state register, opcode latch and per-state decode of the control word

module cpu_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              mem_rdata,
    input  logic                    a_max,
    output cpu_pkg::alu_a_sel_e     alu_a_sel,
    output cpu_pkg::alu_b_sel_e     alu_b_sel,
    output cpu_pkg::alu_ctl_e       alu_ctl,
    output cpu_pkg::reg_wdata_sel_e reg_wdata_sel,
    output cpu_pkg::pc_wdata_sel_e  pc_wdata_sel,
    output logic [1:0]              a_write,
    output logic [1:0]              x_write,
    output logic [1:0]              y_write,
    output logic                    sp_write,
    output logic                    sp_inc,
    output logic                    dbr_write,
    output logic                    pc_write,
    output logic [2:0]              addr_write,
    output logic                    mv_byte,
    output cpu_pkg::mem_addr_sel_e  mem_addr_sel,
    output cpu_pkg::mem_wdata_sel_e mem_wdata_sel,
    output logic                    mem_read,
    output logic                    mem_write,
    output logic                    halted
);

    cpu_pkg::state_e state, state_next;
    logic [7:0] opcode;
    logic       run;     // low for the first cycle out of reset
    logic [1:0] tgt;     // 0 a, 1 x, 2 y
    logic [1:0] wr_mask; // byte mask for the target register
    logic       mv_dec;

    // ======================================================================
    // state and opcode registers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= cpu_pkg::S_FETCH_OPCODE;
            opcode <= 8'h00;
            run    <= 1'b0;
        end else begin
            run   <= 1'b1;
            state <= state_next;
            if (run && (state == cpu_pkg::S_FETCH_OPCODE)) begin
                opcode <= mem_rdata;
            end
        end
    end

    always_comb begin
        case (opcode)
            cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_PHX, cpu_pkg::OP_PLX: tgt = 2'd1;
            cpu_pkg::OP_LDY_IMM, cpu_pkg::OP_PHY, cpu_pkg::OP_PLY: tgt = 2'd2;
            default: tgt = 2'd0;
        endcase
    end

    assign mv_dec = (opcode == cpu_pkg::OP_MVP); // MVP walks downward
    assign halted = (state == cpu_pkg::S_HALT);

    // ======================================================================
    // control decode
    // ======================================================================
    always_comb begin
        alu_a_sel     = cpu_pkg::AA_0;
        alu_b_sel     = cpu_pkg::AB_RD;
        alu_ctl       = cpu_pkg::ACTL_ADD;
        reg_wdata_sel = cpu_pkg::RW_ALUY;
        pc_wdata_sel  = cpu_pkg::PCW_PC_1;
        mem_addr_sel  = cpu_pkg::MA_PC;
        mem_wdata_sel = cpu_pkg::MW_AL;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        a_write       = 2'b00;
        x_write       = 2'b00;
        y_write       = 2'b00;
        wr_mask       = 2'b00;
        sp_write      = 1'b0;
        sp_inc        = 1'b0;
        dbr_write     = 1'b0;
        pc_write      = 1'b0;
        addr_write    = 3'b000;
        mv_byte       = 1'b0;
        state_next    = cpu_pkg::S_FETCH_OPCODE;

        case (state)
            cpu_pkg::S_FETCH_OPCODE: begin
                if (run) begin
                    mem_read = 1'b1; // opcode at pc
                    pc_write = 1'b1;
                    case (mem_rdata)
                        cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDY_IMM:
                            state_next = cpu_pkg::S_FETCH_OPRAND_L;
                        cpu_pkg::OP_PHA, cpu_pkg::OP_PHX, cpu_pkg::OP_PHY:
                            state_next = cpu_pkg::S_PUSH_H;
                        cpu_pkg::OP_PLA, cpu_pkg::OP_PLX, cpu_pkg::OP_PLY:
                            state_next = cpu_pkg::S_PULL_L;
                        cpu_pkg::OP_MVN, cpu_pkg::OP_MVP:
                            state_next = cpu_pkg::S_FETCH_BANK;
                        cpu_pkg::OP_STP:
                            state_next = cpu_pkg::S_HALT;
                        default:
                            state_next = cpu_pkg::S_FETCH_OPCODE; // nop
                    endcase
                end
            end
            cpu_pkg::S_FETCH_OPRAND_L, cpu_pkg::S_FETCH_OPRAND_H: begin
                mem_read = 1'b1;
                pc_write = 1'b1;
                // 0 + mem byte into the address register
                if (state == cpu_pkg::S_FETCH_OPRAND_L) begin
                    addr_write[cpu_pkg::L] = 1'b1;
                    state_next = cpu_pkg::S_FETCH_OPRAND_H;
                end else begin
                    addr_write[cpu_pkg::H] = 1'b1;
                    state_next = cpu_pkg::S_OP_CALC;
                end
            end
            cpu_pkg::S_OP_CALC: begin
                reg_wdata_sel = cpu_pkg::RW_ADDR; // immediate to register
                wr_mask = 2'b11;
            end
            cpu_pkg::S_PUSH_H, cpu_pkg::S_PUSH_L: begin
                mem_addr_sel = cpu_pkg::MA_SP;
                mem_write = 1'b1;
                alu_a_sel = cpu_pkg::AA_SP; // sp - 1
                alu_b_sel = cpu_pkg::AB_1;
                alu_ctl = cpu_pkg::ACTL_SUB;
                sp_write = 1'b1;
                if (state == cpu_pkg::S_PUSH_H) begin
                    case (tgt)
                        2'd1: mem_wdata_sel = cpu_pkg::MW_XH;
                        2'd2: mem_wdata_sel = cpu_pkg::MW_YH;
                        default: mem_wdata_sel = cpu_pkg::MW_AH;
                    endcase
                    state_next = cpu_pkg::S_PUSH_L;
                end else begin
                    case (tgt)
                        2'd1: mem_wdata_sel = cpu_pkg::MW_XL;
                        2'd2: mem_wdata_sel = cpu_pkg::MW_YL;
                        default: mem_wdata_sel = cpu_pkg::MW_AL;
                    endcase
                end
            end
            cpu_pkg::S_PULL_L, cpu_pkg::S_PULL_H: begin
                mem_addr_sel = cpu_pkg::MA_SP_1;
                mem_read = 1'b1;
                sp_inc = 1'b1;
                reg_wdata_sel = cpu_pkg::RW_RD;
                if (state == cpu_pkg::S_PULL_L) begin
                    wr_mask = 2'b01;
                    state_next = cpu_pkg::S_PULL_H;
                end else begin
                    wr_mask = 2'b10;
                end
            end
            cpu_pkg::S_FETCH_BANK: begin
                mem_read = 1'b1; // dbr from the operand
                reg_wdata_sel = cpu_pkg::RW_RD;
                dbr_write = 1'b1;
                pc_write = 1'b1;
                state_next = cpu_pkg::S_MV_READ;
            end
            cpu_pkg::S_MV_READ: begin
                mem_addr_sel = cpu_pkg::MA_X;
                mem_read = 1'b1;
                addr_write[cpu_pkg::L] = 1'b1; // hold the byte in flight
                mv_byte = 1'b1;
                alu_a_sel = cpu_pkg::AA_X;
                alu_b_sel = cpu_pkg::AB_1;
                alu_ctl = mv_dec ? cpu_pkg::ACTL_SUB : cpu_pkg::ACTL_ADD;
                x_write = 2'b11;
                state_next = cpu_pkg::S_MV_WRITE;
            end
            cpu_pkg::S_MV_WRITE: begin
                mem_addr_sel = cpu_pkg::MA_Y;
                mem_wdata_sel = cpu_pkg::MW_ADDRL;
                mem_write = 1'b1;
                alu_a_sel = cpu_pkg::AA_Y;
                alu_b_sel = cpu_pkg::AB_1;
                alu_ctl = mv_dec ? cpu_pkg::ACTL_SUB : cpu_pkg::ACTL_ADD;
                y_write = 2'b11;
                state_next = cpu_pkg::S_DEC_A;
            end
            cpu_pkg::S_DEC_A: begin
                alu_a_sel = cpu_pkg::AA_A; // byte count - 1
                alu_b_sel = cpu_pkg::AB_1;
                alu_ctl = cpu_pkg::ACTL_SUB;
                a_write = 2'b11;
                state_next = cpu_pkg::S_MV_LOOP;
            end
            cpu_pkg::S_MV_LOOP: begin
                // back to the opcode unless a wrapped to ffff
                alu_a_sel = cpu_pkg::AA_PC;
                alu_b_sel = cpu_pkg::AB_2;
                alu_ctl = cpu_pkg::ACTL_SUB;
                pc_wdata_sel = cpu_pkg::PCW_ALUY;
                pc_write = !a_max;
            end
            cpu_pkg::S_HALT: begin
                state_next = cpu_pkg::S_HALT; // until reset
            end
            default: ;
        endcase

        case (tgt)
            2'd1: x_write = x_write | wr_mask;
            2'd2: y_write = y_write | wr_mask;
            default: a_write = a_write | wr_mask;
        endcase
    end

endmodule

// File: hdl/mem_port.sv
`timescale 1ns/1ps
// mini816 memory port
// picks the bus address and the outgoing data byte

module mem_port (
    input  cpu_pkg::mem_addr_sel_e  mem_addr_sel,
    input  cpu_pkg::mem_wdata_sel_e mem_wdata_sel,
    input  logic [15:0]             pc,
    input  logic [15:0]             sp,
    input  logic [15:0]             x,
    input  logic [15:0]             y,
    input  logic [7:0]              dbr,
    input  logic [15:0]             a,
    input  cpu_pkg::long_addr_u     addr,
    output cpu_pkg::long_addr_u     mem_addr,
    output logic [7:0]              mem_wdata
);

    logic [15:0] sp_1;

    assign sp_1 = sp + 16'd1; // pulls read above sp

    always_comb begin
        mem_addr.f.bank = 8'h00; // code and stack live in bank 0
        case (mem_addr_sel)
            cpu_pkg::MA_SP:   mem_addr.f.offset = sp;
            cpu_pkg::MA_SP_1: mem_addr.f.offset = sp_1;
            cpu_pkg::MA_X: begin
                mem_addr.f.bank   = dbr;
                mem_addr.f.offset = x;
            end
            cpu_pkg::MA_Y: begin
                mem_addr.f.bank   = dbr;
                mem_addr.f.offset = y;
            end
            default:          mem_addr.f.offset = pc;
        endcase
    end

    always_comb begin
        case (mem_wdata_sel)
            cpu_pkg::MW_AH: mem_wdata = a[15:8];
            cpu_pkg::MW_XL: mem_wdata = x[7:0];
            cpu_pkg::MW_XH: mem_wdata = x[15:8];
            cpu_pkg::MW_YL: mem_wdata = y[7:0];
            cpu_pkg::MW_YH: mem_wdata = y[15:8];
            cpu_pkg::MW_ADDRL: mem_wdata = addr.bytes[cpu_pkg::L];
            default:        mem_wdata = a[7:0];
        endcase
    end

endmodule

// File: hdl/mini816_top.sv
`timescale 1ns/1ps
// mini816 core top level
// connects the sequencer to the ALU, registers, address register and memory port

module mini816_top #(
    parameter logic [15:0] RESET_PC = 16'h0200,
    parameter logic [15:0] SP_RESET = 16'h01FF
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [7:0]          mem_rdata,
    output cpu_pkg::long_addr_u mem_addr,
    output logic [7:0]          mem_wdata,
    output logic                mem_read,
    output logic                mem_write,
    output logic                halted
);

    cpu_pkg::alu_a_sel_e     alu_a_sel;
    cpu_pkg::alu_b_sel_e     alu_b_sel;
    cpu_pkg::alu_ctl_e       alu_ctl;
    cpu_pkg::reg_wdata_sel_e reg_wdata_sel;
    cpu_pkg::pc_wdata_sel_e  pc_wdata_sel;
    cpu_pkg::mem_addr_sel_e  mem_addr_sel;
    cpu_pkg::mem_wdata_sel_e mem_wdata_sel;
    cpu_pkg::long_addr_u     addr;

    logic [1:0]  a_write, x_write, y_write;
    logic        sp_write, sp_inc, dbr_write, pc_write;
    logic [2:0]  addr_write;
    logic        mv_byte, a_max;
    logic [15:0] alu_y, a, x, y, sp, pc;
    logic [7:0]  dbr;

    cpu_sequencer u_seq (
        .clk, .rst_n, .mem_rdata, .a_max,
        .alu_a_sel, .alu_b_sel, .alu_ctl, .reg_wdata_sel, .pc_wdata_sel,
        .a_write, .x_write, .y_write, .sp_write, .sp_inc, .dbr_write, .pc_write,
        .addr_write, .mv_byte, .mem_addr_sel, .mem_wdata_sel,
        .mem_read, .mem_write, .halted
    );

    alu_unit u_alu (
        .alu_a_sel, .alu_b_sel, .alu_ctl, .a, .x, .y, .sp, .pc,
        .addr_off (addr.f.offset),
        .mem_rdata, .alu_y
    );

    reg_file #(
        .RESET_PC (RESET_PC),
        .SP_RESET (SP_RESET)
    ) u_regs (
        .clk, .rst_n, .a_write, .x_write, .y_write, .sp_write, .sp_inc,
        .dbr_write, .pc_write, .reg_wdata_sel, .pc_wdata_sel, .alu_y,
        .addr_off (addr.f.offset),
        .mem_rdata, .a, .x, .y, .sp, .dbr, .pc, .a_max
    );

    addr_reg u_addr (
        .clk, .rst_n, .addr_write,
        .alu_y (alu_y[7:0]), // only the low byte is ever written
        .mem_rdata, .mv_byte, .addr
    );

    mem_port u_mport (
        .mem_addr_sel, .mem_wdata_sel, .pc, .sp, .x, .y, .dbr, .a, .addr,
        .mem_addr, .mem_wdata
    );

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps
// mini816 register file
// A, X, Y with byte writes, plus SP, DBR and PC with their incrementers

module reg_file #(
    parameter logic [15:0] RESET_PC = 16'h0200,
    parameter logic [15:0] SP_RESET = 16'h01FF
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [1:0]              a_write,
    input  logic [1:0]              x_write,
    input  logic [1:0]              y_write,
    input  logic                    sp_write,
    input  logic                    sp_inc,
    input  logic                    dbr_write,
    input  logic                    pc_write,
    input  cpu_pkg::reg_wdata_sel_e reg_wdata_sel,
    input  cpu_pkg::pc_wdata_sel_e  pc_wdata_sel,
    input  logic [15:0]             alu_y,
    input  logic [15:0]             addr_off,
    input  logic [7:0]              mem_rdata,
    output logic [15:0]             a,
    output logic [15:0]             x,
    output logic [15:0]             y,
    output logic [15:0]             sp,
    output logic [7:0]              dbr,
    output logic [15:0]             pc,
    output logic                    a_max
);

    logic [15:0] reg_wdata;
    logic [15:0] gpr [3];    // a, x, y
    logic [1:0]  gpr_we [3];

    always_comb begin
        case (reg_wdata_sel)
            cpu_pkg::RW_ALUY: reg_wdata = alu_y;
            cpu_pkg::RW_ADDR: reg_wdata = addr_off;
            default:          reg_wdata = {mem_rdata, mem_rdata}; // same byte both halves
        endcase
    end

    assign gpr_we[0] = a_write;
    assign gpr_we[1] = x_write;
    assign gpr_we[2] = y_write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                gpr[i] <= 16'h0000;
            end
            sp  <= SP_RESET;
            dbr <= 8'h00;
            pc  <= RESET_PC;
        end else begin
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 2; j++) begin
                    if (gpr_we[i][j]) begin
                        gpr[i][j*8 +: 8] <= reg_wdata[j*8 +: 8];
                    end
                end
            end
            if (sp_write) begin
                sp <= reg_wdata;
            end else if (sp_inc) begin
                sp <= sp + 16'd1; // pull side
            end
            if (dbr_write) begin
                dbr <= reg_wdata[7:0];
            end
            if (pc_write) begin
                pc <= (pc_wdata_sel == cpu_pkg::PCW_ALUY) ? alu_y : pc + 16'd1;
            end
        end
    end

    assign a = gpr[0];
    assign x = gpr[1];
    assign y = gpr[2];
    assign a_max = (gpr[0] == 16'hFFFF); // block move done

endmodule

// File: mini816.f
+incdir+test
hdl/cpu_pkg.sv
hdl/alu_unit.sv
hdl/reg_file.sv
hdl/addr_reg.sv
hdl/mem_port.sv
hdl/cpu_sequencer.sv
hdl/mini816_top.sv
test/mini816_tb.sv

// File: test/mini816_model.svh
// mini816 reference model
// runs a program instruction by instruction on its own memory copy
// and keeps the expected bus writes in order
`ifndef MINI816_MODEL_SVH
`define MINI816_MODEL_SVH

logic [7:0]          ref_mem [0:65535];
cpu_pkg::long_addr_u exp_addr [$];
logic [7:0]          exp_data [$];
logic [15:0]         m_a, m_x, m_y, m_sp, m_pc;
logic [7:0]          m_dbr;
int                  exp_reads; // cycles with mem_read high

task automatic record_write(input logic [7:0] bank, input logic [15:0] off,
                            input logic [7:0] data);
    cpu_pkg::long_addr_u la;
    la.f.bank    = bank;
    la.f.offset  = off;
    ref_mem[off] = data; // flat 64 KB, every bank maps here
    exp_addr.push_back(la);
    exp_data.push_back(data);
endtask

task automatic push_word(input logic [15:0] v);
    record_write(8'h00, m_sp, v[15:8]); // high byte first
    m_sp = m_sp - 16'd1;
    record_write(8'h00, m_sp, v[7:0]);
    m_sp = m_sp - 16'd1;
endtask

task automatic pull_word(output logic [15:0] v);
    exp_reads = exp_reads + 2; // low and high byte reads
    m_sp    = m_sp + 16'd1;
    v[7:0]  = ref_mem[m_sp];
    m_sp    = m_sp + 16'd1;
    v[15:8] = ref_mem[m_sp];
endtask

task automatic execute_program(input logic [15:0] start);
    logic [7:0]  op;
    logic [15:0] imm;
    int          steps;
    m_a   = 16'h0000;
    m_x   = 16'h0000;
    m_y   = 16'h0000;
    m_sp  = 16'h01FF;
    m_dbr = 8'h00;
    m_pc  = start;
    exp_addr.delete();
    exp_data.delete();
    exp_reads = 0;
    op    = 8'h00;
    steps = 0;
    while (op != cpu_pkg::OP_STP && steps < 10000) begin
        op   = ref_mem[m_pc];
        exp_reads = exp_reads + 1; // opcode fetch
        m_pc = m_pc + 16'd1;
        imm  = {ref_mem[m_pc + 16'd1], ref_mem[m_pc]}; // little endian operand
        case (op)
            cpu_pkg::OP_LDA_IMM: begin
                m_a  = imm;
                m_pc = m_pc + 16'd2;
                exp_reads = exp_reads + 2;
            end
            cpu_pkg::OP_LDX_IMM: begin
                m_x  = imm;
                m_pc = m_pc + 16'd2;
                exp_reads = exp_reads + 2;
            end
            cpu_pkg::OP_LDY_IMM: begin
                m_y  = imm;
                m_pc = m_pc + 16'd2;
                exp_reads = exp_reads + 2;
            end
            cpu_pkg::OP_PHA: push_word(m_a);
            cpu_pkg::OP_PHX: push_word(m_x);
            cpu_pkg::OP_PHY: push_word(m_y);
            cpu_pkg::OP_PLA: pull_word(m_a);
            cpu_pkg::OP_PLX: pull_word(m_x);
            cpu_pkg::OP_PLY: pull_word(m_y);
            cpu_pkg::OP_MVN, cpu_pkg::OP_MVP: begin
                m_dbr = ref_mem[m_pc]; // bank operand
                m_pc  = m_pc + 16'd1;
                do begin
                    exp_reads = exp_reads + 2; // bank operand and source byte
                    record_write(m_dbr, m_y, ref_mem[m_x]);
                    if (op == cpu_pkg::OP_MVP) begin
                        m_x = m_x - 16'd1;
                        m_y = m_y - 16'd1;
                    end else begin
                        m_x = m_x + 16'd1;
                        m_y = m_y + 16'd1;
                    end
                    m_a = m_a - 16'd1;
                    if (m_a != 16'hFFFF) begin
                        exp_reads = exp_reads + 1; // opcode fetched again
                    end
                end while (m_a != 16'hFFFF);
            end
            default: ; // stp and unknown opcodes
        endcase
        steps++;
    end
endtask

`endif

// File: test/mini816_tb.sv
`timescale 1ns/1ps
// mini816 testbench
// random programs run on the core and on a reference model,
// bus writes and final memory compared

module mini816_tb;

    logic                clk = 1'b0;
    logic                rst_n = 1'b0;
    logic [7:0]          mem_rdata;
    cpu_pkg::long_addr_u mem_addr;
    logic [7:0]          mem_wdata;
    logic                mem_read, mem_write, halted;

    logic [7:0]          mem [0:65535];
    logic [7:0]          prog [$];
    cpu_pkg::long_addr_u got_addr [$];
    logic [7:0]          got_data [$];
    int                  got_reads;
    int                  test_errs;
    int                  n_pass, n_fail;

    `include "mini816_model.svh"

    mini816_top #(
        .RESET_PC (16'h0200),
        .SP_RESET (16'h01FF)
    ) dut0 (
        .clk, .rst_n, .mem_rdata, .mem_addr, .mem_wdata,
        .mem_read, .mem_write, .halted
    );

    always #4 clk = ~clk;

    assign mem_rdata = mem[mem_addr.f.offset]; // combinational read

    // ======================================================================
    // memory write side and write log
    // ======================================================================
    always @(negedge clk) begin
        if (mem_read) begin
            got_reads++;
        end
        if (mem_write) begin
            mem[mem_addr.f.offset] = mem_wdata;
            got_addr.push_back(mem_addr);
            got_data.push_back(mem_wdata);
        end
    end

    task automatic check_addr(input string name, input cpu_pkg::long_addr_u got,
                              input cpu_pkg::long_addr_u exp);
        if (got !== exp) begin
            $display("ERROR %s: got %06h, expected %06h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %02h, expected %02h", name, got, exp);
            test_errs++;
        end
    endtask

    // ======================================================================
    // program generation
    // ======================================================================
    task automatic put_byte(input logic [7:0] b);
        prog.push_back(b);
    endtask

    function automatic logic [7:0] push_op(input int r);
        case (r)
            1: return cpu_pkg::OP_PHX;
            2: return cpu_pkg::OP_PHY;
            default: return cpu_pkg::OP_PHA;
        endcase
    endfunction

    function automatic logic [7:0] pull_op(input int r);
        case (r)
            1: return cpu_pkg::OP_PLX;
            2: return cpu_pkg::OP_PLY;
            default: return cpu_pkg::OP_PLA;
        endcase
    endfunction

    task automatic load_imm(input int r, input logic [15:0] v);
        case (r)
            1: put_byte(cpu_pkg::OP_LDX_IMM);
            2: put_byte(cpu_pkg::OP_LDY_IMM);
            default: put_byte(cpu_pkg::OP_LDA_IMM);
        endcase
        put_byte(v[7:0]);
        put_byte(v[15:8]);
    endtask

    task automatic block_move(input bit down);
        logic [15:0] src;
        logic [15:0] dst;
        src = 16'h4100 + 16'($urandom % 32'h3000); // source window
        dst = 16'h8100 + 16'($urandom % 32'h3000); // well clear of source
        load_imm(0, 16'($urandom % 32'd16));       // count - 1
        load_imm(1, src);
        load_imm(2, dst);
        put_byte(down ? cpu_pkg::OP_MVP : cpu_pkg::OP_MVN);
        put_byte(8'($urandom)); // data bank
    endtask

    // ======================================================================
    // reset and run
    // ======================================================================
    task automatic reset_core();
        rst_n = 1'b0;
        repeat (8) begin
            @(negedge clk);
            check_byte("mem_read", {7'd0, mem_read}, 8'h00);
            check_byte("mem_write", {7'd0, mem_write}, 8'h00);
            @(posedge clk);
        end
        #1 rst_n = 1'b1;
        @(negedge clk); // first cycle out of reset is idle too
        check_byte("mem_read", {7'd0, mem_read}, 8'h00);
        check_byte("mem_write", {7'd0, mem_write}, 8'h00);
        @(posedge clk);
        #1;
    endtask

    task automatic run_program(input string name);
        int i;
        int cyc;
        int n_writes;
        int bad;
        test_errs = 0;
        rst_n = 1'b0;
        put_byte(cpu_pkg::OP_PHA); // registers become visible as writes
        put_byte(cpu_pkg::OP_PHX);
        put_byte(cpu_pkg::OP_PHY);
        put_byte(cpu_pkg::OP_STP);
        for (i = 0; i < 65536; i++) begin
            mem[i[15:0]] = 8'($urandom);
        end
        for (i = 0; i < prog.size(); i++) begin
            mem[16'h0200 + i[15:0]] = prog[i];
        end
        for (i = 0; i < 65536; i++) begin
            ref_mem[i[15:0]] = mem[i[15:0]];
        end
        execute_program(16'h0200);
        got_addr.delete();
        got_data.delete();
        got_reads = 0;
        reset_core();
        cyc = 0;
        while (!halted && cyc < 20000) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!halted) begin
            $display("%s: halted never rose within 20000 cycles", name);
            test_errs++;
        end else begin
            n_writes = got_addr.size();
            repeat (50) @(posedge clk);
            #1;
            if (got_addr.size() != n_writes) begin
                $display("%s: %0d writes occurred after halted rose", name,
                         got_addr.size() - n_writes);
                test_errs++;
            end
        end
        if (got_reads != exp_reads) begin
            $display("%s: %0d read cycles seen, %0d expected", name, got_reads,
                     exp_reads);
            test_errs++;
        end
        if (got_addr.size() != exp_addr.size()) begin
            $display("%s: %0d writes seen, %0d expected", name, got_addr.size(),
                     exp_addr.size());
            test_errs++;
        end
        for (i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
            check_addr("mem_addr", got_addr[i], exp_addr[i]);
            check_byte("mem_wdata", got_data[i], exp_data[i]);
        end
        bad = 0;
        for (i = 0; i < 65536 && bad < 4; i++) begin
            if (mem[i[15:0]] !== ref_mem[i[15:0]]) begin
                check_byte($sformatf("mem[%04h]", i), mem[i[15:0]], ref_mem[i[15:0]]);
                bad++;
            end
        end
        prog.delete();
        if (test_errs == 0) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("%s: %s, %0d writes", name, (test_errs == 0) ? "passed" : "failed",
                 got_addr.size());
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        int round;
        int k;
        int r;
        int s;
        n_pass = 0;
        n_fail = 0;
        test_errs = 0;
        void'($urandom(50330));
        for (round = 0; round < 2; round++) begin
            run_program($sformatf("reset_%0d", round));
            for (k = 0; k < 6; k++) begin
                load_imm(int'($urandom % 3), 16'($urandom));
                put_byte(push_op(int'($urandom % 3)));
            end
            run_program($sformatf("push_%0d", round));
            for (k = 0; k < 4; k++) begin
                r = int'($urandom % 3);
                s = (r + 1 + int'($urandom % 2)) % 3; // a different register
                load_imm(r, 16'($urandom));
                put_byte(push_op(r));
                put_byte(pull_op(s));
                put_byte(push_op(s));
            end
            run_program($sformatf("pull_%0d", round));
            block_move(1'b0);
            block_move(1'b0);
            run_program($sformatf("mvn_%0d", round));
            block_move(1'b1);
            block_move(1'b1);
            run_program($sformatf("mvp_%0d", round));
            load_imm(0, 16'($urandom));
            put_byte(8'hEA); // unknown opcode, runs as nop
            put_byte(push_op(0));
            put_byte(pull_op(2));
            block_move(($urandom % 2) == 1);
            load_imm(1, 16'($urandom));
            run_program($sformatf("stp_%0d", round));
        end
        $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
